// File: hw/cmd_stream_if.sv
`timescale 1ns/1ps

// tagged payload bytes in clk_sys, from the sync stage to the endpoints
interface cmd_stream_if;

	// one cycle per payload byte, never for the command byte
	logic       valid;
	// payload byte
	logic [7:0] data;
	// command latched from the first byte of the transfer
	logic [7:0] cmd;
	// payload position, 1 for the first payload byte
	logic [3:0] pos;
	// SS high seen in clk_sys
	logic       xfer_end;

	modport source (
		output valid, data, cmd, pos, xfer_end
	);

	modport sink (
		input valid, data, cmd, pos, xfer_end
	);

endinterface

// File: hw/cmd_sync.sv
`timescale 1ns/1ps

module cmd_sync
	import io_link_pkg::*;
(
	input  logic         clk_sys,
	input  logic         SPI_SS_IO,
	input  byte_t        rx_byte_i,
	input  logic         rx_toggle_i,
	cmd_stream_if.source stream
);

	// toggle from the SPI clock, two flops then one for the edge
	logic [1:0]       tog_sync;
	logic             tog_seen;
	// SS level, two flops
	logic [1:0]       end_sync;
	// bytes seen in this transfer, command included
	logic [POS_W-1:0] byte_cnt;
	// a new byte has landed in rx_byte_i
	logic             new_byte;

	always_ff @(posedge clk_sys) begin
		tog_sync <= {tog_sync[0], rx_toggle_i};
		tog_seen <= tog_sync[1];
		end_sync <= {end_sync[0], SPI_SS_IO};
	end

	assign new_byte        = tog_sync[1] ^ tog_seen;
	assign stream.xfer_end = end_sync[1];

	// rx_byte_i has been stable for two cycles when new_byte fires
	always_ff @(posedge clk_sys) begin
		stream.valid <= 1'b0;
		if (stream.xfer_end) begin
			byte_cnt   <= '0;
			stream.pos <= '0;
		end else if (new_byte) begin
			// saturate at 15
			if (byte_cnt != '1) begin
				byte_cnt <= byte_cnt + 1'b1;
			end
			if (byte_cnt == '0) begin
				// first byte is the command, no valid for it
				stream.cmd <= rx_byte_i;
			end else begin
				stream.valid <= 1'b1;
				stream.data  <= rx_byte_i;
				stream.pos   <= byte_cnt;
			end
		end
	end

endmodule

// File: hw/core_regs.sv
`timescale 1ns/1ps

module core_regs
	import io_link_pkg::*;
#(
	parameter int NUM_JOY = 5
) (
	input  logic                          clk_sys,
	cmd_stream_if.sink                    stream,
	output byte_t                         but_sw_o,
	output logic [NUM_JOY-1:0][JOY_W-1:0] joystick_o,
	output logic [STATUS_W-1:0]           status_o
);

	// joystick number addressed by the command
	cmd_t       joy_sel;
	// byte lane inside a word, pos 1 is lane 0
	logic [2:0] lane;

	assign joy_sel = stream.cmd - CMD_JOY_BASE;
	assign lane    = 3'(stream.pos - 4'd1);

	// buttons and switches, one byte
	always_ff @(posedge clk_sys) begin
		if (stream.valid && stream.cmd == CMD_BUT_SW) begin
			but_sw_o <= stream.data;
		end
	end

	// status word, little-endian, bytes past the 8th dropped
	always_ff @(posedge clk_sys) begin
		if (stream.valid && stream.cmd == CMD_STATUS && stream.pos <= 4'd8) begin
			status_o[lane*8 +: 8] <= stream.data;
		end
	end

	// one 32-bit word per joystick, little-endian
	always_ff @(posedge clk_sys) begin
		for (int k = 0; k < NUM_JOY; k++) begin
			// fifth byte and later ignored
			if (stream.valid && joy_sel == cmd_t'(k) && stream.pos <= 4'd4) begin
				joystick_o[k][lane[1:0]*8 +: 8] <= stream.data;
			end
		end
	end

endmodule

// File: hw/io_link.sv
`timescale 1ns/1ps

module io_link
	import io_link_pkg::*;
#(
	parameter int NUM_JOY = 5
) (
	input  logic                          clk_sys,
	input  logic                          SPI_SS_IO,
	input  logic                          spi_clk_i,
	input  logic                          spi_mosi_i,
	output logic [1:0]                    buttons_o,
	output logic [1:0]                    switches_o,
	output logic                          scandoubler_disable_o,
	output logic                          ypbpr_o,
	output logic                          no_csync_o,
	output logic [NUM_JOY-1:0][JOY_W-1:0] joystick_o,
	output logic [STATUS_W-1:0]           status_o,
	output byte_t                         key_code_o,
	output logic                          key_pressed_o,
	output logic                          key_extended_o,
	output logic                          key_strobe_o,
	output logic [8:0]                    mouse_x_o,
	output logic [8:0]                    mouse_y_o,
	output logic [3:0]                    mouse_z_o,
	output byte_t                         mouse_flags_o,
	output logic                          mouse_idx_o,
	output logic                          mouse_strobe_o
);

	// SPI clock side
	byte_t rx_byte;
	logic  rx_toggle;
	byte_t but_sw;

	cmd_stream_if cmd_stream ();

	spi_byte_rx u_spi_byte_rx (
		.spi_clk_i   (spi_clk_i),
		.spi_mosi_i  (spi_mosi_i),
		.SPI_SS_IO   (SPI_SS_IO),
		.rx_byte_o   (rx_byte),
		.rx_toggle_o (rx_toggle)
	);

	// into clk_sys
	cmd_sync u_cmd_sync (
		.clk_sys     (clk_sys),
		.SPI_SS_IO   (SPI_SS_IO),
		.rx_byte_i   (rx_byte),
		.rx_toggle_i (rx_toggle),
		.stream      (cmd_stream)
	);

	core_regs #(
		.NUM_JOY (NUM_JOY)
	) u_core_regs (
		.clk_sys    (clk_sys),
		.stream     (cmd_stream),
		.but_sw_o   (but_sw),
		.joystick_o (joystick_o),
		.status_o   (status_o)
	);

	key_decoder u_key_decoder (
		.clk_sys        (clk_sys),
		.SPI_SS_IO      (SPI_SS_IO),
		.stream         (cmd_stream),
		.key_code_o     (key_code_o),
		.key_pressed_o  (key_pressed_o),
		.key_extended_o (key_extended_o),
		.key_strobe_o   (key_strobe_o)
	);

	mouse_packer u_mouse_packer (
		.clk_sys        (clk_sys),
		.SPI_SS_IO      (SPI_SS_IO),
		.stream         (cmd_stream),
		.mouse_x_o      (mouse_x_o),
		.mouse_y_o      (mouse_y_o),
		.mouse_z_o      (mouse_z_o),
		.mouse_flags_o  (mouse_flags_o),
		.mouse_idx_o    (mouse_idx_o),
		.mouse_strobe_o (mouse_strobe_o)
	);

	// button/switch byte fields, bit 7 spare
	assign buttons_o             = but_sw[1:0];
	assign switches_o            = but_sw[3:2];
	assign scandoubler_disable_o = but_sw[4];
	assign ypbpr_o               = but_sw[5];
	assign no_csync_o            = but_sw[6];

endmodule

// File: hw/io_link_pkg.sv
package io_link_pkg;

	// one SPI byte and one command code
	typedef logic [7:0] byte_t;
	typedef logic [7:0] cmd_t;

	// command codes from the IO controller
	localparam cmd_t CMD_BUT_SW   = 8'h01;
	localparam cmd_t CMD_KBD      = 8'h05;
	localparam cmd_t CMD_STATUS   = 8'h1e;
	localparam cmd_t CMD_JOY_BASE = 8'h60;
	localparam cmd_t CMD_MOUSE0   = 8'h70;
	localparam cmd_t CMD_MOUSE1   = 8'h71;

	// keyboard prefix bytes
	localparam byte_t KEY_EXT_PREFIX   = 8'he0;
	localparam byte_t KEY_BREAK_PREFIX = 8'hf0;

	localparam int JOY_W    = 32;
	localparam int STATUS_W = 64;
	// byte position saturates at 15
	localparam int POS_W    = 4;

	// mouse flags byte, high bit first
	typedef struct packed {
		logic y_ovf;
		logic x_ovf;
		logic dy8;
		logic dx8;
		logic one;
		logic btn_mid;
		logic btn_right;
		logic btn_left;
	} mouse_bits_t;

	typedef union packed {
		byte_t       raw;
		mouse_bits_t bits;
	} mouse_flags_u;

endpackage

// File: hw/key_decoder.sv
`timescale 1ns/1ps

module key_decoder
	import io_link_pkg::*;
(
	input  logic       clk_sys,
	input  logic       SPI_SS_IO,
	cmd_stream_if.sink stream,
	output byte_t      key_code_o,
	output logic       key_pressed_o,
	output logic       key_extended_o,
	output logic       key_strobe_o
);

	// flags collected from prefix bytes
	logic ext_pend;
	logic press_pend;
	// flags that apply to the byte on the stream
	logic ext_now;
	logic press_now;
	logic kbd_byte;
	logic is_prefix;

	assign kbd_byte  = stream.valid && stream.cmd == CMD_KBD;
	assign is_prefix = stream.data == KEY_EXT_PREFIX || stream.data == KEY_BREAK_PREFIX;

	// first payload byte starts a fresh make code
	always_comb begin
		ext_now   = ext_pend;
		press_now = press_pend;
		if (stream.pos == 4'd1) begin
			ext_now   = 1'b0;
			press_now = 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (stream.xfer_end) begin
			ext_pend   <= 1'b0;
			press_pend <= 1'b1;
		end else if (kbd_byte) begin
			ext_pend   <= ext_now || stream.data == KEY_EXT_PREFIX;
			press_pend <= press_now && stream.data != KEY_BREAK_PREFIX;
		end
	end

	// key event on every non-prefix byte
	always_ff @(posedge clk_sys) begin
		if (kbd_byte && !is_prefix) begin
			key_code_o     <= stream.data;
			key_pressed_o  <= press_now;
			key_extended_o <= ext_now;
		end
	end

	always_ff @(posedge clk_sys or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			key_strobe_o <= 1'b0;
		end else begin
			key_strobe_o <= kbd_byte && !is_prefix;
		end
	end

endmodule

// File: hw/mouse_packer.sv
`timescale 1ns/1ps

module mouse_packer
	import io_link_pkg::*;
(
	input  logic       clk_sys,
	input  logic       SPI_SS_IO,
	cmd_stream_if.sink stream,
	output logic [8:0] mouse_x_o,
	output logic [8:0] mouse_y_o,
	output logic [3:0] mouse_z_o,
	output byte_t      mouse_flags_o,
	output logic       mouse_idx_o,
	output logic       mouse_strobe_o
);

	// bytes 1 to 3 of the packet
	mouse_flags_u flags_q;
	byte_t        x_q;
	byte_t        y_q;
	logic         mouse_byte;
	logic         pkt_done;

	// 0x70 is mouse 0, 0x71 is mouse 1
	assign mouse_byte = stream.valid &&
		(stream.cmd == CMD_MOUSE0 || stream.cmd == CMD_MOUSE1);
	// z byte closes the packet
	assign pkt_done = mouse_byte && stream.pos == 4'd4;

	always_ff @(posedge clk_sys) begin
		if (mouse_byte) begin
			case (stream.pos)
				4'd1: flags_q.raw <= stream.data;
				4'd2: x_q <= stream.data;
				4'd3: y_q <= stream.data;
				default: ;
			endcase
		end
	end

	// dx8 and dy8 are the sign bits of the deltas
	always_ff @(posedge clk_sys) begin
		if (pkt_done) begin
			mouse_x_o     <= {flags_q.bits.dx8, x_q};
			mouse_y_o     <= {flags_q.bits.dy8, y_q};
			mouse_z_o     <= stream.data[3:0];
			mouse_flags_o <= flags_q.raw;
			mouse_idx_o   <= stream.cmd[0];
		end
	end

	always_ff @(posedge clk_sys or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			mouse_strobe_o <= 1'b0;
		end else begin
			mouse_strobe_o <= pkt_done;
		end
	end

endmodule

// File: hw/spi_byte_rx.sv
`timescale 1ns/1ps

module spi_byte_rx
	import io_link_pkg::*;
(
	input  logic  spi_clk_i,
	input  logic  spi_mosi_i,
	input  logic  SPI_SS_IO,
	output byte_t rx_byte_o,
	output logic  rx_toggle_o
);

	// bit index inside the current byte
	logic [2:0] bit_cnt;
	// first seven bits of the byte, MSB first
	logic [6:0] sbuf;
	// flips once per completed byte
	logic       toggle_q = 1'b0;

	// counter and shift register restart with every transfer
	always_ff @(posedge spi_clk_i or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			bit_cnt <= '0;
			sbuf    <= '0;
		end else begin
			bit_cnt <= bit_cnt + 3'd1;
			sbuf    <= {sbuf[5:0], spi_mosi_i};
		end
	end

	// 8th edge, the current MOSI bit is the LSB
	always_ff @(posedge spi_clk_i) begin
		if (bit_cnt == 3'd7) begin
			rx_byte_o <= {sbuf, spi_mosi_i};
			toggle_q  <= ~toggle_q;
		end
	end

	assign rx_toggle_o = toggle_q;

endmodule

// File: io_link.f
hw/io_link_pkg.sv
hw/cmd_stream_if.sv
hw/spi_byte_rx.sv
hw/cmd_sync.sv
hw/core_regs.sv
hw/key_decoder.sv
hw/mouse_packer.sv
hw/io_link.sv
tb/io_link_assert.sv
tb/io_link_tb.sv

// File: tb/io_link_assert.sv
`timescale 1ns/1ps

// strobe and stream rules of one endpoint
module io_link_assert (
	input logic       clk_sys,
	input logic       SPI_SS_IO,
	input logic       strobe_i,
	input logic       valid_i,
	input logic [3:0] pos_i
);

	// failures seen so far, read by the testbench
	int fail_cnt = 0;

	// an event strobe is a single-cycle pulse
	strobe_one_cycle: assert property (@(posedge clk_sys) disable iff (SPI_SS_IO)
		strobe_i |=> !strobe_i)
	else begin
		$error("strobe high for more than one cycle");
		fail_cnt++;
	end

	// payload bytes always carry a position, 0 is idle
	valid_has_pos: assert property (@(posedge clk_sys) disable iff (SPI_SS_IO)
		valid_i |-> pos_i != 4'd0)
	else begin
		$error("stream valid with pos 0");
		fail_cnt++;
	end

endmodule

bind key_decoder io_link_assert strobe_chk (
	.clk_sys   (clk_sys),
	.SPI_SS_IO (SPI_SS_IO),
	.strobe_i  (key_strobe_o),
	.valid_i   (stream.valid),
	.pos_i     (stream.pos)
);

bind mouse_packer io_link_assert strobe_chk (
	.clk_sys   (clk_sys),
	.SPI_SS_IO (SPI_SS_IO),
	.strobe_i  (mouse_strobe_o),
	.valid_i   (stream.valid),
	.pos_i     (stream.pos)
);

// File: tb/io_link_tb.sv
`timescale 1ns/1ps

module io_link_tb
	import io_link_pkg::*;
();

	localparam int NUM_JOY     = 5;
	localparam int CLK_HALF_NS = 4;
	// SCK half period in clk_sys cycles, 40 ns
	localparam int SCK_HALF    = 5;
	localparam int N_BUT       = 4;
	localparam int N_MOUSE     = 8;
	// bytes and transfers of the whole run, command bytes included
	localparam int N_BYTES     = N_BUT * 2 + (NUM_JOY + 1) * 6 + 9 + 12 + N_MOUSE * 5;
	localparam int N_XFERS     = N_BUT + NUM_JOY + 1 + 1 + 4 + N_MOUSE;
	localparam int WATCHDOG_NS = N_BYTES * 16 * SCK_HALF * 2 * CLK_HALF_NS + N_XFERS * 400 + 5000;

	logic                          clk_sys;
	logic                          SPI_SS_IO;
	logic                          spi_clk;
	logic                          spi_mosi;
	logic [1:0]                    buttons;
	logic [1:0]                    switches;
	logic                          scandoubler_disable;
	logic                          ypbpr;
	logic                          no_csync;
	logic [NUM_JOY-1:0][JOY_W-1:0] joystick;
	logic [STATUS_W-1:0]           status;
	byte_t                         key_code;
	logic                          key_pressed;
	logic                          key_extended;
	logic                          key_strobe;
	logic [8:0]                    mouse_x;
	logic [8:0]                    mouse_y;
	logic [3:0]                    mouse_z;
	byte_t                         mouse_flags;
	logic                          mouse_idx;
	logic                          mouse_strobe;

	// expected state, X until written, as in the DUT
	byte_t               exp_but_sw;
	logic [JOY_W-1:0]    exp_joy [0:NUM_JOY-1];
	logic [STATUS_W-1:0] exp_status;
	// pending keyboard flags and mouse bytes of the model
	logic                kext;
	logic                kpress;
	byte_t               m_flags;
	byte_t               m_x;
	byte_t               m_y;
	// {extended, pressed, code}
	logic [9:0]          key_q [$];
	// {idx, flags, z, y, x}
	logic [30:0]         mouse_q [$];
	logic [9:0]          exp_key;
	logic [30:0]         exp_mouse;
	byte_t               tx_buf [0:15];
	int unsigned         lcg_state = 32'd7244;
	int                  val_errs = 0;
	int                  proto_errs = 0;
	int                  assert_errs;

	io_link #(
		.NUM_JOY (NUM_JOY)
	) dut (
		.clk_sys               (clk_sys),
		.SPI_SS_IO             (SPI_SS_IO),
		.spi_clk_i             (spi_clk),
		.spi_mosi_i            (spi_mosi),
		.buttons_o             (buttons),
		.switches_o            (switches),
		.scandoubler_disable_o (scandoubler_disable),
		.ypbpr_o               (ypbpr),
		.no_csync_o            (no_csync),
		.joystick_o            (joystick),
		.status_o              (status),
		.key_code_o            (key_code),
		.key_pressed_o         (key_pressed),
		.key_extended_o        (key_extended),
		.key_strobe_o          (key_strobe),
		.mouse_x_o             (mouse_x),
		.mouse_y_o             (mouse_y),
		.mouse_z_o             (mouse_z),
		.mouse_flags_o         (mouse_flags),
		.mouse_idx_o           (mouse_idx),
		.mouse_strobe_o        (mouse_strobe)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_HALF_NS) clk_sys = ~clk_sys;
	end

	// 32-bit LCG, top byte taken
	function automatic byte_t next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:24];
	endfunction

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			val_errs++;
			$display("[ERROR] %s: got %h expected %h", name, got, exp);
		end
	endtask

	// reference model, one payload byte at a time
	function automatic void model_byte(input cmd_t cmd, input int pos, input byte_t data);
		if (cmd == CMD_BUT_SW) begin
			exp_but_sw = data;
		end
		// joystick k takes bytes 1 to 4, little-endian
		if (cmd >= CMD_JOY_BASE && cmd < CMD_JOY_BASE + NUM_JOY && pos <= 4) begin
			exp_joy[int'(cmd - CMD_JOY_BASE)][8 * (pos - 1) +: 8] = data;
		end
		if (cmd == CMD_STATUS && pos <= 8) begin
			exp_status[8 * (pos - 1) +: 8] = data;
		end
		if (cmd == CMD_KBD) begin
			// each transfer starts as a plain make code
			if (pos == 1) begin
				kext   = 1'b0;
				kpress = 1'b1;
			end
			if (data == KEY_EXT_PREFIX) begin
				kext = 1'b1;
			end else if (data == KEY_BREAK_PREFIX) begin
				kpress = 1'b0;
			end else begin
				key_q.push_back({kext, kpress, data});
			end
		end
		if (cmd == CMD_MOUSE0 || cmd == CMD_MOUSE1) begin
			case (pos)
				1: m_flags = data;
				2: m_x = data;
				3: m_y = data;
				// dx8 is flags bit 4, dy8 is bit 5
				4: mouse_q.push_back({cmd[0], m_flags, data[3:0], m_flags[5], m_y, m_flags[4], m_x});
				default: ;
			endcase
		end
	endfunction

	// one transfer of tx_buf, mode 0, MSB first, SCK paced by clk_sys falling edges
	task automatic send_xfer(input int len);
		int i;
		int b;
		SPI_SS_IO = 1'b0;
		for (i = 0; i < len; i++) begin
			for (b = 7; b >= 0; b--) begin
				spi_mosi = tx_buf[i][b];
				repeat (SCK_HALF) @(negedge clk_sys);
				spi_clk = 1'b1;
				repeat (SCK_HALF) @(negedge clk_sys);
				spi_clk = 1'b0;
			end
		end
		// let the last byte land before SS rises, then keep SS high
		repeat (10) @(negedge clk_sys);
		SPI_SS_IO = 1'b1;
		spi_mosi  = 1'b0;
		repeat (12) @(negedge clk_sys);
	endtask

	task automatic check_regs();
		int k;
		check_val("buttons_o", buttons, exp_but_sw[1:0]);
		check_val("switches_o", switches, exp_but_sw[3:2]);
		check_val("scandoubler_disable_o", scandoubler_disable, exp_but_sw[4]);
		check_val("ypbpr_o", ypbpr, exp_but_sw[5]);
		check_val("no_csync_o", no_csync, exp_but_sw[6]);
		for (k = 0; k < NUM_JOY; k++) begin
			check_val($sformatf("joystick_o[%0d]", k), joystick[k], exp_joy[k]);
		end
		check_val("status_o", status, exp_status);
	endtask

	// every expected event must have been seen by now
	task automatic check_drained();
		if (key_q.size() != 0) begin
			proto_errs++;
			$display("%0d expected key events never got a strobe", key_q.size());
			key_q.delete();
		end
		if (mouse_q.size() != 0) begin
			proto_errs++;
			$display("%0d expected mouse packets never got a strobe", mouse_q.size());
			mouse_q.delete();
		end
	endtask

	task automatic run_xfer(input int len);
		int p;
		for (p = 1; p < len; p++) begin
			model_byte(tx_buf[0], p, tx_buf[p]);
		end
		send_xfer(len);
		check_regs();
		check_drained();
	endtask

	// outputs move on the rising edge, sampled on the falling one
	always @(negedge clk_sys) begin
		if (key_strobe === 1'b1) begin
			if (key_q.size() == 0) begin
				proto_errs++;
				$display("key strobe with no key event expected");
			end else begin
				exp_key = key_q.pop_front();
				check_val("key_code_o", key_code, exp_key[7:0]);
				check_val("key_pressed_o", key_pressed, exp_key[8]);
				check_val("key_extended_o", key_extended, exp_key[9]);
			end
		end
		if (mouse_strobe === 1'b1) begin
			if (mouse_q.size() == 0) begin
				proto_errs++;
				$display("mouse strobe with no mouse packet expected");
			end else begin
				exp_mouse = mouse_q.pop_front();
				check_val("mouse_x_o", mouse_x, exp_mouse[8:0]);
				check_val("mouse_y_o", mouse_y, exp_mouse[17:9]);
				check_val("mouse_z_o", mouse_z, exp_mouse[21:18]);
				check_val("mouse_flags_o", mouse_flags, exp_mouse[29:22]);
				check_val("mouse_idx_o", mouse_idx, exp_mouse[30]);
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the last transfer finished");
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		int i;
		int j;
		SPI_SS_IO = 1'b1;
		spi_clk   = 1'b0;
		spi_mosi  = 1'b0;
		repeat (16) @(negedge clk_sys);
		check_val("key_strobe_o", key_strobe, 1'b0);
		check_val("mouse_strobe_o", mouse_strobe, 1'b0);
		// buttons and switches
		for (i = 0; i < N_BUT; i++) begin
			tx_buf[0] = CMD_BUT_SW;
			tx_buf[1] = next_rand();
			run_xfer(2);
		end
		// every joystick plus one past the last, five payload bytes each
		for (i = 0; i <= NUM_JOY; i++) begin
			tx_buf[0] = CMD_JOY_BASE + i;
			for (j = 1; j <= 5; j++) begin
				tx_buf[j] = next_rand();
			end
			run_xfer(6);
		end
		tx_buf[0] = CMD_STATUS;
		for (j = 1; j <= 8; j++) begin
			tx_buf[j] = next_rand();
		end
		run_xfer(9);
		// make, break, extended make, extended break
		tx_buf[0] = CMD_KBD;
		tx_buf[1] = 8'h1c;
		run_xfer(2);
		tx_buf[1] = KEY_BREAK_PREFIX;
		tx_buf[2] = 8'h1c;
		run_xfer(3);
		tx_buf[1] = KEY_EXT_PREFIX;
		tx_buf[2] = 8'h75;
		run_xfer(3);
		tx_buf[1] = KEY_EXT_PREFIX;
		tx_buf[2] = KEY_BREAK_PREFIX;
		tx_buf[3] = 8'h75;
		run_xfer(4);
		// mice alternate, flags keep the always-one bit
		for (i = 0; i < N_MOUSE; i++) begin
			tx_buf[0] = (i % 2 == 1) ? CMD_MOUSE1 : CMD_MOUSE0;
			tx_buf[1] = next_rand() | 8'h08;
			tx_buf[2] = next_rand();
			tx_buf[3] = next_rand();
			tx_buf[4] = next_rand();
			run_xfer(5);
		end
		assert_errs = dut.u_key_decoder.strobe_chk.fail_cnt + dut.u_mouse_packer.strobe_chk.fail_cnt;
		$display("errors: %0d value, %0d protocol, %0d assertion", val_errs, proto_errs, assert_errs);
		if (val_errs + proto_errs + assert_errs == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule
